//--- ix_pkg.sv
`default_nettype none

package ix_pkg;

    localparam int XLEN    = 64;
    localparam int REG_W   = 5;
    localparam int NUM_SRC = 4;
    localparam int IMM_W   = 64;

    // ALU operation, carried to the pipe untouched
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA,
        ALU_SLT,
        ALU_SLTU
    } alu_op_e;

    // Operand 1 source, ZIMM is the rs1 field zero-extended
    typedef enum logic [1:0] {
        OPR1_RS1,
        OPR1_PC,
        OPR1_ZERO,
        OPR1_ZIMM
    } opr1_sel_e;

    typedef enum logic [1:0] {
        OPR2_RS2,
        OPR2_IMM,
        OPR2_FOUR
    } opr2_sel_e;

    // One decoded instruction slot
    typedef struct packed {
        logic [XLEN-1:0]  pc;
        alu_op_e          alu_op;
        opr1_sel_e        opr1_sel;
        opr2_sel_e        opr2_sel;
        logic [IMM_W-1:0] imm;
        logic             wb_en;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [REG_W-1:0] rd;
    } dec_slot_t;

endpackage

`default_nettype wire

//--- ix_src_if.sv
`timescale 1ns/1ps
`default_nettype none

// One register source, from slot decode through its resolver to issue control
interface ix_src_if;
    import ix_pkg::*;

    logic [REG_W-1:0] idx;
    logic             ready;
    logic [XLEN-1:0]  value;

    modport decode (output idx);

    modport resolve (input idx, output ready, output value);

    modport issue (input ready, input value);

endinterface

`default_nettype wire

//--- ix_bypass_if.sv
`timescale 1ns/1ps
`default_nettype none

// Result state of the pipes, seen by every operand resolver
interface ix_bypass_if;
    import ix_pkg::*;

    // Writeback buffer
    logic                        wb_buf_valid;
    logic [REG_W-1:0]            wb_buf_dst;
    logic [XLEN-1:0]             wb_buf_value;

    // Writeback stage, indexed by pipe
    logic [1:0]                  wb_valid;
    logic [1:0]                  wb_en;
    logic [1:0][REG_W-1:0]       wb_dst;
    logic [1:0][XLEN-1:0]        wb_result;

    // Execute result of the entry held in each issue register
    logic [1:0][XLEN-1:0]        forwarding;

    // Issue register state, published by issue control
    logic [1:0]                  ex_valid;
    logic [1:0]                  ex_wb_en;
    logic [1:0][REG_W-1:0]       ex_dst;
    logic [1:0]                  ex_accept;

    modport source (
        output wb_buf_valid, wb_buf_dst, wb_buf_value,
        output wb_valid, wb_en, wb_dst, wb_result,
        output forwarding
    );

    modport resolve (
        input wb_buf_valid, wb_buf_dst, wb_buf_value,
        input wb_valid, wb_en, wb_dst, wb_result,
        input forwarding,
        input ex_valid, ex_wb_en, ex_dst, ex_accept
    );

    modport exec (output ex_valid, ex_wb_en, ex_dst, ex_accept);

endinterface

`default_nettype wire

//--- ix_slot_decode.sv
`timescale 1ns/1ps
`default_nettype none

module ix_slot_decode (
    input  ix_pkg::dec_slot_t          dec0_slot,
    input  ix_pkg::dec_slot_t          dec1_slot,
    input  logic                       dec0_valid,
    input  logic                       dec1_valid,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc0,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc1,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc2,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc3,
    ix_src_if.decode                   src [ix_pkg::NUM_SRC],
    output logic                       pair_indep
);
    import ix_pkg::*;

    logic slot1_reads_rs1;
    logic slot1_reads_rs2;
    logic raw_hazard;
    logic waw_hazard;

    // Source order is slot 0 rs1, slot 0 rs2, slot 1 rs1, slot 1 rs2
    assign src[0].idx = dec0_slot.rs1;
    assign src[1].idx = dec0_slot.rs2;
    assign src[2].idx = dec1_slot.rs1;
    assign src[3].idx = dec1_slot.rs2;

    assign rf_rsrc0 = src[0].idx;
    assign rf_rsrc1 = src[1].idx;
    assign rf_rsrc2 = src[2].idx;
    assign rf_rsrc3 = src[3].idx;

    // Slot 1 only depends on a register field that it actually selects
    assign slot1_reads_rs1 = (dec1_slot.opr1_sel == OPR1_RS1);
    assign slot1_reads_rs2 = (dec1_slot.opr2_sel == OPR2_RS2);

    // Slot 1 reads what slot 0 is about to write
    assign raw_hazard = dec0_slot.wb_en &&
            ((slot1_reads_rs1 && (dec1_slot.rs1 == dec0_slot.rd)) ||
             (slot1_reads_rs2 && (dec1_slot.rs2 == dec0_slot.rd)));

    // Both slots write the same register
    assign waw_hazard = dec0_slot.wb_en && dec1_slot.wb_en &&
            (dec0_slot.rd == dec1_slot.rd);

    assign pair_indep = dec0_valid && dec1_valid && !raw_hazard && !waw_hazard;

endmodule

`default_nettype wire

//--- ix_operand_resolve.sv
`timescale 1ns/1ps
`default_nettype none

module ix_operand_resolve (
    ix_src_if.resolve                src,
    input  logic [ix_pkg::XLEN-1:0]  rdata,
    ix_bypass_if.resolve             byp
);
    import ix_pkg::*;

    logic            ready;
    logic [XLEN-1:0] value;

    // Later assignments win, so older producers come first
    always_comb begin
        value = rdata;
        ready = 1'b1;

        if (byp.wb_buf_valid && (byp.wb_buf_dst == src.idx)) begin
            value = byp.wb_buf_value;
        end

        // Writeback stage of pipe 0, then pipe 1
        for (int p = 0; p < 2; p++) begin
            if (byp.wb_valid[p] && byp.wb_en[p] && (byp.wb_dst[p] == src.idx)) begin
                value = byp.wb_result[p];
            end
        end

        // Execute stage, only usable while the pipe takes the entry
        for (int p = 0; p < 2; p++) begin
            if (byp.ex_valid[p] && byp.ex_wb_en[p] && byp.ex_accept[p] &&
                    (byp.ex_dst[p] == src.idx)) begin
                value = byp.forwarding[p];
            end
        end

        // Held entry still owes this register its result
        for (int p = 0; p < 2; p++) begin
            if (byp.ex_valid[p] && byp.ex_wb_en[p] && !byp.ex_accept[p] &&
                    (byp.ex_dst[p] == src.idx)) begin
                ready = 1'b0;
            end
        end

        // x0 overrides any bypass that claims to write it
        if (src.idx == '0) begin
            ready = 1'b1;
            value = '0;
        end
    end

    assign src.ready = ready;
    assign src.value = value;

endmodule

`default_nettype wire

//--- ix_issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module ix_issue_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pipe_flush,
    input  ix_pkg::dec_slot_t          dec0_slot,
    input  ix_pkg::dec_slot_t          dec1_slot,
    input  logic                       dec0_valid,
    input  logic                       dec1_valid,
    input  logic                       pair_indep,
    ix_src_if.issue                    src [ix_pkg::NUM_SRC],
    ix_bypass_if.exec                  byp,
    input  logic                       ip0_ready,
    input  logic                       ip1_ready,
    output logic                       dec0_ready,
    output logic                       dec1_ready,
    output logic                       ip0_valid,
    output ix_pkg::alu_op_e            ip0_op,
    output logic [ix_pkg::XLEN-1:0]    ip0_operand1,
    output logic [ix_pkg::XLEN-1:0]    ip0_operand2,
    output logic [ix_pkg::REG_W-1:0]   ip0_dst,
    output logic                       ip0_wb_en,
    output logic [ix_pkg::XLEN-1:0]    ip0_pc,
    output logic                       ip1_valid,
    output ix_pkg::alu_op_e            ip1_op,
    output logic [ix_pkg::XLEN-1:0]    ip1_operand1,
    output logic [ix_pkg::XLEN-1:0]    ip1_operand2,
    output logic [ix_pkg::REG_W-1:0]   ip1_dst,
    output logic                       ip1_wb_en,
    output logic [ix_pkg::XLEN-1:0]    ip1_pc
);
    import ix_pkg::*;

    dec_slot_t             slot [2];
    logic [1:0]            slot_valid;
    logic [NUM_SRC-1:0]    rs_ready;
    logic [XLEN-1:0]       rs_value [NUM_SRC];
    logic [XLEN-1:0]       opr1 [2];
    logic [XLEN-1:0]       opr2 [2];
    logic [1:0]            opr_ready;
    logic [1:0]            pipe_ready;
    logic [1:0]            pipe_free;
    logic [1:0]            issue;
    logic                  issue_ok;

    // Issue registers, index is the pipe number
    logic [1:0]            pipe_valid;
    alu_op_e               pipe_op [2];
    logic [1:0][XLEN-1:0]  pipe_opr1;
    logic [1:0][XLEN-1:0]  pipe_opr2;
    logic [1:0][REG_W-1:0] pipe_dst;
    logic [1:0]            pipe_wb_en;
    logic [1:0][XLEN-1:0]  pipe_pc;

    assign slot[0]    = dec0_slot;
    assign slot[1]    = dec1_slot;
    assign slot_valid = {dec1_valid, dec0_valid};
    assign pipe_ready = {ip1_ready, ip0_ready};

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_src
        assign rs_ready[s] = src[s].ready;
        assign rs_value[s] = src[s].value;
    end

    // Slot k owns sources 2k and 2k+1
    always_comb begin
        for (int k = 0; k < 2; k++) begin
            unique case (slot[k].opr1_sel)
                OPR1_RS1:  opr1[k] = rs_value[2*k];
                OPR1_PC:   opr1[k] = slot[k].pc;
                OPR1_ZERO: opr1[k] = '0;
                OPR1_ZIMM: opr1[k] = XLEN'(slot[k].rs1);
            endcase
            case (slot[k].opr2_sel)
                OPR2_RS2:  opr2[k] = rs_value[2*k+1];
                OPR2_IMM:  opr2[k] = slot[k].imm;
                OPR2_FOUR: opr2[k] = XLEN'(4);
                default:   opr2[k] = '0;
            endcase
            opr_ready[k] = ((slot[k].opr1_sel != OPR1_RS1) || rs_ready[2*k]) &&
                           ((slot[k].opr2_sel != OPR2_RS2) || rs_ready[2*k+1]);
        end
    end

    // A pipe takes a new entry when empty or when its entry leaves now
    assign pipe_free = ~pipe_valid | pipe_ready;
    assign issue_ok  = !rst && !pipe_flush;

    assign issue[0] = issue_ok && slot_valid[0] && opr_ready[0] && pipe_free[0];
    assign issue[1] = issue[0] && pair_indep && slot_valid[1] && opr_ready[1] &&
                      pipe_free[1];

    assign dec0_ready = issue_ok && (!dec0_valid || issue[0]);
    assign dec1_ready = issue[1];

    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (rst || pipe_flush) begin
                pipe_valid[p] <= 1'b0;
            end else if (issue[p]) begin
                pipe_valid[p] <= 1'b1;
            end else if (pipe_ready[p]) begin
                pipe_valid[p] <= 1'b0;
            end
        end
    end

    // Payload only changes on issue, so it holds under back-pressure
    always_ff @(posedge clk) begin
        for (int p = 0; p < 2; p++) begin
            if (issue[p]) begin
                pipe_op[p]    <= slot[p].alu_op;
                pipe_opr1[p]  <= opr1[p];
                pipe_opr2[p]  <= opr2[p];
                pipe_dst[p]   <= slot[p].rd;
                pipe_wb_en[p] <= slot[p].wb_en;
                pipe_pc[p]    <= slot[p].pc;
            end
        end
    end

    assign byp.ex_valid  = pipe_valid;
    assign byp.ex_wb_en  = pipe_wb_en;
    assign byp.ex_dst    = pipe_dst;
    assign byp.ex_accept = pipe_ready;

    assign ip0_valid    = pipe_valid[0];
    assign ip0_op       = pipe_op[0];
    assign ip0_operand1 = pipe_opr1[0];
    assign ip0_operand2 = pipe_opr2[0];
    assign ip0_dst      = pipe_dst[0];
    assign ip0_wb_en    = pipe_wb_en[0];
    assign ip0_pc       = pipe_pc[0];

    assign ip1_valid    = pipe_valid[1];
    assign ip1_op       = pipe_op[1];
    assign ip1_operand1 = pipe_opr1[1];
    assign ip1_operand2 = pipe_opr2[1];
    assign ip1_dst      = pipe_dst[1];
    assign ip1_wb_en    = pipe_wb_en[1];
    assign ip1_pc       = pipe_pc[1];

endmodule

`default_nettype wire

//--- ix_issue.sv
`timescale 1ns/1ps
`default_nettype none

module ix_issue (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       pipe_flush,
    // Decode slots
    input  ix_pkg::dec_slot_t          dec0_slot,
    input  logic                       dec0_valid,
    output logic                       dec0_ready,
    input  ix_pkg::dec_slot_t          dec1_slot,
    input  logic                       dec1_valid,
    output logic                       dec1_ready,
    // Register file, read data returns in the same cycle
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc0,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc1,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc2,
    output logic [ix_pkg::REG_W-1:0]   rf_rsrc3,
    input  logic [ix_pkg::XLEN-1:0]    rf_rdata0,
    input  logic [ix_pkg::XLEN-1:0]    rf_rdata1,
    input  logic [ix_pkg::XLEN-1:0]    rf_rdata2,
    input  logic [ix_pkg::XLEN-1:0]    rf_rdata3,
    // Writeback buffer
    input  logic                       wb_buf_valid,
    input  logic [ix_pkg::REG_W-1:0]   wb_buf_dst,
    input  logic [ix_pkg::XLEN-1:0]    wb_buf_value,
    // Writeback stage of each pipe, ipN_wb_wb_en is the stage's write enable
    input  logic                       ip0_wb_valid,
    input  logic                       ip0_wb_wb_en,
    input  logic [ix_pkg::REG_W-1:0]   ip0_wb_dst,
    input  logic [ix_pkg::XLEN-1:0]    ip0_wb_result,
    input  logic                       ip1_wb_valid,
    input  logic                       ip1_wb_wb_en,
    input  logic [ix_pkg::REG_W-1:0]   ip1_wb_dst,
    input  logic [ix_pkg::XLEN-1:0]    ip1_wb_result,
    input  logic [ix_pkg::XLEN-1:0]    ip0_forwarding,
    input  logic [ix_pkg::XLEN-1:0]    ip1_forwarding,
    // Integer pipe 0
    output logic                       ip0_valid,
    input  logic                       ip0_ready,
    output ix_pkg::alu_op_e            ip0_op,
    output logic [ix_pkg::XLEN-1:0]    ip0_operand1,
    output logic [ix_pkg::XLEN-1:0]    ip0_operand2,
    output logic [ix_pkg::REG_W-1:0]   ip0_dst,
    output logic                       ip0_wb_en,
    output logic [ix_pkg::XLEN-1:0]    ip0_pc,
    // Integer pipe 1
    output logic                       ip1_valid,
    input  logic                       ip1_ready,
    output ix_pkg::alu_op_e            ip1_op,
    output logic [ix_pkg::XLEN-1:0]    ip1_operand1,
    output logic [ix_pkg::XLEN-1:0]    ip1_operand2,
    output logic [ix_pkg::REG_W-1:0]   ip1_dst,
    output logic                       ip1_wb_en,
    output logic [ix_pkg::XLEN-1:0]    ip1_pc
);
    import ix_pkg::*;

    logic            pair_indep;
    logic [XLEN-1:0] rdata [NUM_SRC];

    ix_src_if    src_if [NUM_SRC] ();
    ix_bypass_if byp_if ();

    assign rdata[0] = rf_rdata0;
    assign rdata[1] = rf_rdata1;
    assign rdata[2] = rf_rdata2;
    assign rdata[3] = rf_rdata3;

    assign byp_if.wb_buf_valid = wb_buf_valid;
    assign byp_if.wb_buf_dst   = wb_buf_dst;
    assign byp_if.wb_buf_value = wb_buf_value;
    assign byp_if.wb_valid     = {ip1_wb_valid, ip0_wb_valid};
    assign byp_if.wb_en        = {ip1_wb_wb_en, ip0_wb_wb_en};
    assign byp_if.wb_dst       = {ip1_wb_dst, ip0_wb_dst};
    assign byp_if.wb_result    = {ip1_wb_result, ip0_wb_result};
    assign byp_if.forwarding   = {ip1_forwarding, ip0_forwarding};

    ix_slot_decode i_slot_decode (
        .dec0_slot  (dec0_slot),
        .dec1_slot  (dec1_slot),
        .dec0_valid (dec0_valid),
        .dec1_valid (dec1_valid),
        .rf_rsrc0   (rf_rsrc0),
        .rf_rsrc1   (rf_rsrc1),
        .rf_rsrc2   (rf_rsrc2),
        .rf_rsrc3   (rf_rsrc3),
        .src        (src_if),
        .pair_indep (pair_indep)
    );

    for (genvar s = 0; s < NUM_SRC; s++) begin : g_resolve
        ix_operand_resolve i_operand_resolve (
            .src   (src_if[s]),
            .rdata (rdata[s]),
            .byp   (byp_if)
        );
    end

    ix_issue_ctrl i_issue_ctrl (
        .clk          (clk),
        .rst          (rst),
        .pipe_flush   (pipe_flush),
        .dec0_slot    (dec0_slot),
        .dec1_slot    (dec1_slot),
        .dec0_valid   (dec0_valid),
        .dec1_valid   (dec1_valid),
        .pair_indep   (pair_indep),
        .src          (src_if),
        .byp          (byp_if),
        .ip0_ready    (ip0_ready),
        .ip1_ready    (ip1_ready),
        .dec0_ready   (dec0_ready),
        .dec1_ready   (dec1_ready),
        .ip0_valid    (ip0_valid),
        .ip0_op       (ip0_op),
        .ip0_operand1 (ip0_operand1),
        .ip0_operand2 (ip0_operand2),
        .ip0_dst      (ip0_dst),
        .ip0_wb_en    (ip0_wb_en),
        .ip0_pc       (ip0_pc),
        .ip1_valid    (ip1_valid),
        .ip1_op       (ip1_op),
        .ip1_operand1 (ip1_operand1),
        .ip1_operand2 (ip1_operand2),
        .ip1_dst      (ip1_dst),
        .ip1_wb_en    (ip1_wb_en),
        .ip1_pc       (ip1_pc)
    );

endmodule

`default_nettype wire

//--- tb_ix_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ix_assertions (
    input logic                    clk,
    input logic                    rst,
    input logic                    pipe_flush,
    input logic                    dec0_valid,
    input logic                    dec0_ready,
    input logic                    dec1_valid,
    input logic                    dec1_ready,
    input logic                    ip0_valid,
    input logic                    ip0_ready,
    input logic                    ip1_valid,
    input logic [ix_pkg::XLEN-1:0] ip0_operand1,
    input logic [ix_pkg::XLEN-1:0] ip0_pc
);

    int fail_count;

    initial begin
        fail_count = 0;
    end

    a_reset_clears: assert property (@(posedge clk)
            rst |=> !ip0_valid && !ip1_valid)
        else begin
            $error("Pipe valid still high after reset");
            fail_count++;
        end

    a_flush_clears: assert property (@(posedge clk)
            pipe_flush |=> !ip0_valid && !ip1_valid)
        else begin
            $error("Pipe valid still high after flush");
            fail_count++;
        end

    a_blocked: assert property (@(posedge clk)
            (rst || pipe_flush) |-> !dec0_ready && !dec1_ready)
        else begin
            $error("Decode ready high during reset or flush");
            fail_count++;
        end

    a_latency: assert property (@(posedge clk) disable iff (rst)
            dec0_valid && dec0_ready |=> ip0_valid)
        else begin
            $error("Issued slot 0 not valid on pipe 0 one cycle later");
            fail_count++;
        end

    a_latency1: assert property (@(posedge clk) disable iff (rst)
            dec1_valid && dec1_ready |=> ip1_valid)
        else begin
            $error("Issued slot 1 not valid on pipe 1 one cycle later");
            fail_count++;
        end

    a_hold: assert property (@(posedge clk) disable iff (rst || pipe_flush)
            ip0_valid && !ip0_ready |=> ip0_valid && $stable(ip0_pc) && $stable(ip0_operand1))
        else begin
            $error("Pipe 0 entry changed under back-pressure");
            fail_count++;
        end

endmodule

bind ix_issue_ctrl tb_ix_assertions i_ix_assertions (.*);

`default_nettype wire

//--- tb_ix_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ix_checker (
    input  logic                     clk, rst, pipe_flush,
    input  ix_pkg::dec_slot_t        dec0_slot, dec1_slot,
    input  logic                     dec0_valid, dec1_valid, dec0_ready, dec1_ready,
    input  logic [ix_pkg::REG_W-1:0] rf_rsrc0, rf_rsrc1, rf_rsrc2, rf_rsrc3,
    input  logic [ix_pkg::XLEN-1:0]  rf_mem [32],
    input  logic                     wb_buf_valid,
    input  logic [ix_pkg::REG_W-1:0] wb_buf_dst,
    input  logic [ix_pkg::XLEN-1:0]  wb_buf_value,
    input  logic                     ip0_wb_valid, ip0_wb_wb_en, ip1_wb_valid, ip1_wb_wb_en,
    input  logic [ix_pkg::REG_W-1:0] ip0_wb_dst, ip1_wb_dst,
    input  logic [ix_pkg::XLEN-1:0]  ip0_wb_result, ip1_wb_result,
    input  logic [ix_pkg::XLEN-1:0]  ip0_forwarding, ip1_forwarding,
    input  logic                     ip0_ready, ip1_ready, ip0_valid, ip1_valid,
    input  ix_pkg::alu_op_e          ip0_op, ip1_op,
    input  logic [ix_pkg::XLEN-1:0]  ip0_operand1, ip0_operand2, ip0_pc,
    input  logic [ix_pkg::XLEN-1:0]  ip1_operand1, ip1_operand2, ip1_pc,
    input  logic [ix_pkg::REG_W-1:0] ip0_dst, ip1_dst,
    input  logic                     ip0_wb_en, ip1_wb_en,
    output int                       error_count,
    output int                       check_count
);
    import ix_pkg::*;

    // Expected contents of the two pipe registers
    logic [1:0]       mv;
    logic [1:0]       mwb;
    logic [REG_W-1:0] mdst [2];
    alu_op_e          mop [2];
    logic [XLEN-1:0]  mopr1 [2];
    logic [XLEN-1:0]  mopr2 [2];
    logic [XLEN-1:0]  mpc [2];
    logic [1:0]       rdy;

    assign rdy = {ip1_ready, ip0_ready};

    initial begin
        error_count = 0;
        check_count = 0;
        mv = '0;
    end

    task automatic compare(input string name, input logic [XLEN-1:0] got, exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Oldest producer first so that younger results win
    function automatic logic [XLEN-1:0] bypassed_reg(input logic [REG_W-1:0] idx);
        logic [XLEN-1:0] v;
        if (idx == 0) return '0;
        v = rf_mem[idx];
        if (wb_buf_valid && wb_buf_dst == idx) v = wb_buf_value;
        if (ip0_wb_valid && ip0_wb_wb_en && ip0_wb_dst == idx) v = ip0_wb_result;
        if (ip1_wb_valid && ip1_wb_wb_en && ip1_wb_dst == idx) v = ip1_wb_result;
        if (mv[0] && mwb[0] && rdy[0] && mdst[0] == idx) v = ip0_forwarding;
        if (mv[1] && mwb[1] && rdy[1] && mdst[1] == idx) v = ip1_forwarding;
        return v;
    endfunction

    function automatic logic stalled(input logic [REG_W-1:0] idx);
        if (idx == 0) return 1'b0;
        return (mv[0] && mwb[0] && !rdy[0] && mdst[0] == idx) ||
               (mv[1] && mwb[1] && !rdy[1] && mdst[1] == idx);
    endfunction

    function automatic logic [XLEN-1:0] ref_operand(input dec_slot_t s, input int which);
        if (which == 1) begin
            case (s.opr1_sel)
                OPR1_RS1: return bypassed_reg(s.rs1);
                OPR1_PC:  return s.pc;
                OPR1_ZIMM: return XLEN'(s.rs1);
                default:  return '0;
            endcase
        end
        case (s.opr2_sel)
            OPR2_RS2: return bypassed_reg(s.rs2);
            OPR2_IMM: return s.imm;
            default:  return XLEN'(4);
        endcase
    endfunction

    function automatic logic srcs_ready(input dec_slot_t s);
        return (s.opr1_sel != OPR1_RS1 || !stalled(s.rs1)) &&
               (s.opr2_sel != OPR2_RS2 || !stalled(s.rs2));
    endfunction

    always @(posedge clk) begin : compare_proc
        logic      indep;
        logic      open;
        logic [1:0] e;
        dec_slot_t s [2];
        s[0] = dec0_slot;
        s[1] = dec1_slot;
        open = !rst && !pipe_flush;
        indep = dec0_valid && dec1_valid &&
            !(dec0_slot.wb_en && dec1_slot.wb_en && dec0_slot.rd == dec1_slot.rd) &&
            !(dec0_slot.wb_en &&
              ((dec1_slot.opr1_sel == OPR1_RS1 && dec1_slot.rs1 == dec0_slot.rd) ||
               (dec1_slot.opr2_sel == OPR2_RS2 && dec1_slot.rs2 == dec0_slot.rd)));
        e[0] = open && dec0_valid && srcs_ready(dec0_slot) && (!mv[0] || rdy[0]);
        e[1] = e[0] && indep && dec1_valid && srcs_ready(dec1_slot) && (!mv[1] || rdy[1]);
        if (!rst) begin
            // Read addresses follow the source order of the two slots
            compare("rf_rsrc0", rf_rsrc0, dec0_slot.rs1);
            compare("rf_rsrc1", rf_rsrc1, dec0_slot.rs2);
            compare("rf_rsrc2", rf_rsrc2, dec1_slot.rs1);
            compare("rf_rsrc3", rf_rsrc3, dec1_slot.rs2);
            compare("ip0_valid", ip0_valid, mv[0]);
            compare("ip1_valid", ip1_valid, mv[1]);
            if (mv[0]) begin
                compare("ip0_op", ip0_op, mop[0]);
                compare("ip0_operand1", ip0_operand1, mopr1[0]);
                compare("ip0_operand2", ip0_operand2, mopr2[0]);
                compare("ip0_dst", ip0_dst, mdst[0]);
                compare("ip0_wb_en", ip0_wb_en, mwb[0]);
                compare("ip0_pc", ip0_pc, mpc[0]);
            end
            if (mv[1]) begin
                compare("ip1_op", ip1_op, mop[1]);
                compare("ip1_operand1", ip1_operand1, mopr1[1]);
                compare("ip1_operand2", ip1_operand2, mopr2[1]);
                compare("ip1_dst", ip1_dst, mdst[1]);
                compare("ip1_wb_en", ip1_wb_en, mwb[1]);
                compare("ip1_pc", ip1_pc, mpc[1]);
            end
            compare("dec0_ready", dec0_ready, open && (!dec0_valid || e[0]));
            compare("dec1_ready", dec1_ready, e[1]);
        end
        for (int p = 0; p < 2; p++) begin
            if (e[p]) begin
                mop[p]   = s[p].alu_op;
                mopr1[p] = ref_operand(s[p], 1);
                mopr2[p] = ref_operand(s[p], 2);
                mpc[p]   = s[p].pc;
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (!open) begin
                mv[p] = 1'b0;
            end else if (e[p]) begin
                mv[p]   = 1'b1;
                mwb[p]  = s[p].wb_en;
                mdst[p] = s[p].rd;
            end else if (rdy[p]) begin
                mv[p] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_ix_issue.sv
`timescale 1ns/1ps
`default_nettype none

module tb_ix_issue;
    import ix_pkg::*;

    localparam int NUM_CYCLES = 3000;
    localparam int TIMEOUT_NS = (NUM_CYCLES + 20) * 8 * 2;

    logic clk, rst, pipe_flush;
    dec_slot_t dec0_slot, dec1_slot;
    logic dec0_valid, dec1_valid, dec0_ready, dec1_ready;
    logic [REG_W-1:0] rf_rsrc0, rf_rsrc1, rf_rsrc2, rf_rsrc3;
    logic [XLEN-1:0] rf_rdata0, rf_rdata1, rf_rdata2, rf_rdata3;
    logic wb_buf_valid;
    logic [REG_W-1:0] wb_buf_dst;
    logic [XLEN-1:0] wb_buf_value;
    logic ip0_wb_valid, ip0_wb_wb_en, ip1_wb_valid, ip1_wb_wb_en;
    logic [REG_W-1:0] ip0_wb_dst, ip1_wb_dst;
    logic [XLEN-1:0] ip0_wb_result, ip1_wb_result, ip0_forwarding, ip1_forwarding;
    logic ip0_valid, ip0_ready, ip0_wb_en, ip1_valid, ip1_ready, ip1_wb_en;
    alu_op_e ip0_op, ip1_op;
    logic [XLEN-1:0] ip0_operand1, ip0_operand2, ip0_pc;
    logic [XLEN-1:0] ip1_operand1, ip1_operand2, ip1_pc;
    logic [REG_W-1:0] ip0_dst, ip1_dst;

    // Register file model with a combinational read
    logic [XLEN-1:0] rf_mem [32];
    int error_count, check_count;
    int seed;
    logic take0, take1;

    assign rf_rdata0 = rf_mem[rf_rsrc0];
    assign rf_rdata1 = rf_mem[rf_rsrc1];
    assign rf_rdata2 = rf_mem[rf_rsrc2];
    assign rf_rdata3 = rf_mem[rf_rsrc3];

    ix_issue i_ix_issue (.*);

    tb_ix_checker i_checker (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the run did not finish in %0d ns", TIMEOUT_NS);
        $display("Regression failed");
        $finish;
    end

    function automatic int unsigned urand();
        return $unsigned($random(seed));
    endfunction

    // Small register range so that hazards and x0 bypasses happen often
    task automatic new_slot(output dec_slot_t s);
        s.pc       = {$random(seed), $random(seed)};
        s.alu_op   = alu_op_e'(urand() % 10);
        s.opr1_sel = opr1_sel_e'(urand() % 4);
        s.opr2_sel = opr2_sel_e'(urand() % 3);
        s.imm      = {$random(seed), $random(seed)};
        s.wb_en    = (urand() % 4) != 0;
        s.rs1      = REG_W'(urand() % 4);
        s.rs2      = REG_W'(urand() % 4);
        s.rd       = REG_W'(urand() % 4);
    endtask

    task automatic drive_env();
        wb_buf_valid   = 1'(urand() % 2);
        wb_buf_dst     = REG_W'(urand() % 4);
        wb_buf_value   = {$random(seed), $random(seed)};
        ip0_wb_valid   = 1'(urand() % 2);
        ip0_wb_wb_en   = 1'(urand() % 2);
        ip0_wb_dst     = REG_W'(urand() % 4);
        ip0_wb_result  = {$random(seed), $random(seed)};
        ip1_wb_valid   = 1'(urand() % 2);
        ip1_wb_wb_en   = 1'(urand() % 2);
        ip1_wb_dst     = REG_W'(urand() % 4);
        ip1_wb_result  = {$random(seed), $random(seed)};
        ip0_forwarding = {$random(seed), $random(seed)};
        ip1_forwarding = {$random(seed), $random(seed)};
        ip0_ready      = (urand() % 4) != 0;
        ip1_ready      = (urand() % 4) != 0;
        pipe_flush     = (urand() % 32) == 0;
    endtask

    initial begin
        seed = 32'ha807_5673;
        rst = 1'b1;
        dec0_valid = 1'b0;
        dec1_valid = 1'b0;
        new_slot(dec0_slot);
        new_slot(dec1_slot);
        for (int r = 0; r < 32; r++) begin
            rf_mem[r] = {$random(seed), $random(seed)} | 64'h1;
        end
        drive_env();
        pipe_flush = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int c = 0; c < NUM_CYCLES; c++) begin
            @(posedge clk);
            take0 = dec0_valid && dec0_ready;
            take1 = dec1_valid && dec1_ready;
            #1;
            // Decoder moves a leftover slot 1 into slot 0
            if (!dec0_valid || take0) begin
                if (take0 && !take1 && dec1_valid) begin
                    dec0_slot = dec1_slot;
                end else begin
                    new_slot(dec0_slot);
                    dec0_valid = (urand() % 8) != 0;
                end
                new_slot(dec1_slot);
                dec1_valid = dec0_valid && ((urand() % 4) != 0);
            end
            drive_env();
        end
        dec0_valid = 1'b0;
        dec1_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d", check_count,
                 error_count, i_ix_issue.i_issue_ctrl.i_ix_assertions.fail_count);
        if (error_count == 0 &&
                i_ix_issue.i_issue_ctrl.i_ix_assertions.fail_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
ix_pkg.sv
ix_src_if.sv
ix_bypass_if.sv
ix_slot_decode.sv
ix_operand_resolve.sv
ix_issue_ctrl.sv
ix_issue.sv
tb_ix_assertions.sv
tb_ix_checker.sv
tb_ix_issue.sv

//--- Bender.yml
package:
  name: ix_issue

sources:
  - files:
      - ix_pkg.sv
      - ix_src_if.sv
      - ix_bypass_if.sv
      - ix_slot_decode.sv
      - ix_operand_resolve.sv
      - ix_issue_ctrl.sv
      - ix_issue.sv
  - target: test
    files:
      - tb_ix_assertions.sv
      - tb_ix_checker.sv
      - tb_ix_issue.sv
